// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic init
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released shortly after a rising edge
    initial begin
        init = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 init = 1'b0;
    end

endmodule

// ==== bench/mem_subsys_tb.sv ====
`timescale 1ns/1ps

module mem_subsys_tb;

    localparam int N_DELAY_CYCLES = 5;
    localparam int HOLD_CYCLES    = 3;     // Extra cycles req stays high after ack
    localparam int MAX_OPS        = 64;

    logic                  clk, init;
    logic                  icache_req, icache_we, dcache_req, dcache_we;
    logic                  icache_ack, dcache_ack;
    mem_pkg::block_addr_t  icache_addr, dcache_addr;
    mem_pkg::block_data_t  icache_wdata, dcache_wdata, icache_rdata, dcache_rdata;

    // Operations as read from the data file
    bit                    op_is_d  [MAX_OPS];
    bit                    op_we    [MAX_OPS];
    bit                    op_ov    [MAX_OPS];
    mem_pkg::block_addr_t  op_addr  [MAX_OPS];
    logic [63:0]           op_wdata [MAX_OPS];
    logic [63:0]           op_exp   [MAX_OPS];
    logic [63:0]           model    [mem_pkg::N_BLOCKS];   // Reference memory

    int n_ops, n_errors, n_pass, n_fail, cycles, cycle_limit;
    bit loaded, icache_ack_q, dcache_ack_q;

    clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(5)) u_clock_gen (.clk(clk), .init(init));

    mem_subsys_top #(.N_DELAY_CYCLES(N_DELAY_CYCLES)) dut (
        .clk(clk), .init(init),
        .icache_req(icache_req), .icache_ack(icache_ack), .icache_we(icache_we),
        .icache_addr(icache_addr), .icache_wdata(icache_wdata), .icache_rdata(icache_rdata),
        .dcache_req(dcache_req), .dcache_ack(dcache_ack), .dcache_we(dcache_we),
        .dcache_addr(dcache_addr), .dcache_wdata(dcache_wdata), .dcache_rdata(dcache_rdata)
    );

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected, output bit match);
        match = (actual === expected);
        if (!match) begin
            $display("ERR %0t %s actual=%h expected=%h", $time, name, actual, expected);
            n_errors++;
        end
    endtask

    function automatic logic ack_of(input bit is_d);
        return is_d ? dcache_ack : icache_ack;
    endfunction

    function automatic logic [63:0] rdata_of(input bit is_d);
        return is_d ? dcache_rdata : icache_rdata;
    endfunction

    task automatic drive_req(input bit is_d, input logic req, input int idx);
        if (is_d) begin
            dcache_req   = req;
            dcache_we    = op_we[idx];
            dcache_addr  = op_addr[idx];
            dcache_wdata = op_wdata[idx];
        end else begin
            icache_req   = req;
            icache_we    = op_we[idx];
            icache_addr  = op_addr[idx];
            icache_wdata = op_wdata[idx];
        end
    endtask

    // Checks the file's expected value against the model, then applies the op
    task automatic verify_expected(input int idx);
        if (model[op_addr[idx]] !== op_exp[idx]) begin
            $display("data file error: op %0d expects %h but block %h holds %h",
                     idx, op_exp[idx], op_addr[idx], model[op_addr[idx]]);
            n_errors++;
        end
        op_exp[idx] = model[op_addr[idx]];
        if (op_we[idx]) model[op_addr[idx]] = op_wdata[idx];
    endtask

    // One full four-phase transaction on one port
    task automatic run_op(input int idx);
        bit    is_d;
        bit    match;
        int    fails;
        string pname;
        is_d  = op_is_d[idx];
        fails = 0;
        pname = is_d ? "dcache" : "icache";
        @(posedge clk);
        #2 drive_req(is_d, 1'b1, idx);
        do @(negedge clk); while (!ack_of(is_d));
        check_value({pname, "_rdata"}, rdata_of(is_d), op_exp[idx], match);
        fails += !match;
        repeat (HOLD_CYCLES) begin   // ack and rdata must hold while req stays up
            @(negedge clk);
            check_value({pname, "_ack"}, ack_of(is_d), 64'd1, match);
            fails += !match;
            check_value({pname, "_rdata"}, rdata_of(is_d), op_exp[idx], match);
            fails += !match;
        end
        @(posedge clk);
        #2 drive_req(is_d, 1'b0, idx);
        do @(negedge clk); while (ack_of(is_d));
        if (fails == 0) n_pass++;
        else n_fail++;
        $display("op %0d %s %s addr %h: %s", idx, pname, op_we[idx] ? "write" : "read",
                 op_addr[idx], (fails == 0) ? "ok" : "mismatch");
    endtask

    task automatic load_data;
        int fd, code, c;
        byte ch;
        logic [63:0] f_we, f_addr, f_wdata, f_exp, f_ov;
        fd = $fopen("bench/mem_subsys_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            n_errors++;
            return;
        end
        n_ops = 0;
        forever begin
            code = $fscanf(fd, " %c", ch);
            if (code != 1) break;
            if (ch == "#") begin   // Comment runs to end of line
                c = $fgetc(fd);
                while (c != 10 && c != -1) c = $fgetc(fd);
                continue;
            end
            code = $fscanf(fd, "%h %h %h %h %h", f_we, f_addr, f_wdata, f_exp, f_ov);
            if (code != 5 || (ch != "I" && ch != "D") || n_ops >= MAX_OPS) begin
                $display("data file error: malformed line after op %0d", n_ops);
                n_errors++;
                break;
            end
            op_is_d[n_ops]  = (ch == "D");
            op_we[n_ops]    = f_we[0];
            op_addr[n_ops]  = f_addr[mem_pkg::ADDR_BITS-1:0];
            op_wdata[n_ops] = f_wdata;
            op_exp[n_ops]   = f_exp;
            op_ov[n_ops]    = f_ov[0];
            n_ops++;
        end
        $fclose(fd);
    endtask

    // ack must never come up without a request behind it
    always @(negedge clk) begin
        bit match;
        if (icache_ack && !icache_ack_q) check_value("icache_req", icache_req, 64'd1, match);
        if (dcache_ack && !dcache_ack_q) check_value("dcache_req", dcache_req, 64'd1, match);
        icache_ack_q <= icache_ack;
        dcache_ack_q <= dcache_ack;
    end

    always @(posedge clk) begin
        cycles++;
        if (loaded && cycles >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int  i;
        bit  match;
        icache_req   = 1'b0;
        icache_we    = 1'b0;
        icache_addr  = '0;
        icache_wdata = '0;
        dcache_req   = 1'b0;
        dcache_we    = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        n_errors = 0;
        n_pass   = 0;
        n_fail   = 0;
        cycles   = 0;
        for (i = 0; i < mem_pkg::N_BLOCKS; i++) model[i] = '0;
        load_data();
        cycle_limit = n_ops * (N_DELAY_CYCLES + 10) * 2;
        loaded      = 1'b1;

        @(negedge clk);
        while (init) begin   // Both acks quiet during reset
            check_value("icache_ack", icache_ack, 64'd0, match);
            check_value("dcache_ack", dcache_ack, 64'd0, match);
            @(negedge clk);
        end

        i = 0;
        while (i < n_ops) begin
            if (op_ov[i] && i + 1 < n_ops) begin
                if (op_is_d[i] == op_is_d[i+1] || op_addr[i] == op_addr[i+1]) begin
                    $display("data file error: overlapped ops %0d and %0d clash", i, i + 1);
                    n_errors++;
                end
                verify_expected(i);
                verify_expected(i + 1);
                fork
                    run_op(i);
                    run_op(i + 1);
                join
                i += 2;
            end else begin
                verify_expected(i);
                run_op(i);
                i++;
            end
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_pass + n_fail, n_pass, n_fail, n_errors);
        if (n_errors == 0 && n_fail == 0 && n_ops > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== bench/mem_subsys_testdata.txt ====
# port(I/D) we addr wdata expected_rdata overlap_with_next   (all hex)
# reads after reset return zero
I 0 0 0000000000000000 0000000000000000 0
D 0 5 0000000000000000 0000000000000000 0
I 0 f 0000000000000000 0000000000000000 0
D 0 9 0000000000000000 0000000000000000 0
# write then read on the same port, writes return the old block
D 1 3 a5a5a5a50000ffff 0000000000000000 0
D 0 3 0000000000000000 a5a5a5a50000ffff 0
D 1 3 0123456789abcdef a5a5a5a50000ffff 0
D 0 3 0000000000000000 0123456789abcdef 0
I 1 7 deadbeefcafef00d 0000000000000000 0
I 0 7 0000000000000000 deadbeefcafef00d 0
# written through dcache, read through icache
D 1 a 1122334455667788 0000000000000000 0
I 0 a 0000000000000000 1122334455667788 0
# both ports in the same cycle, disjoint blocks
I 0 3 0000000000000000 0123456789abcdef 1
D 1 4 fedcba9876543210 0000000000000000 0
I 1 8 0f0f0f0f0f0f0f0f 0000000000000000 1
D 0 a 0000000000000000 1122334455667788 0
D 0 8 0000000000000000 0f0f0f0f0f0f0f0f 1
I 0 4 0000000000000000 fedcba9876543210 0
D 1 3 ffffffffffffffff 0123456789abcdef 1
I 0 7 0000000000000000 deadbeefcafef00d 0
I 0 3 0000000000000000 ffffffffffffffff 0

// ==== build.f ====
common/mem_pkg.sv
common/mem_req_if.sv
source/client_port.sv
source/mem_arbiter.sv
main_mem/main_mem.sv
source/mem_subsys_top.sv
bench/clock_gen.sv
bench/mem_subsys_tb.sv

// ==== common/mem_pkg.sv ====
package mem_pkg;

    // Block geometry of the main memory
    localparam int BLOCK_BITS = 64;   // One cache line per block
    localparam int N_BLOCKS   = 16;
    localparam int ADDR_BITS  = $clog2(N_BLOCKS);  // 4 for 16 blocks

    // One block of data as moved between caches and memory
    typedef logic [BLOCK_BITS-1:0] block_data_t;

    // Block index into the memory array
    typedef logic [ADDR_BITS-1:0] block_addr_t;

    // Operation carried by a request
    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1    // Store, response carries old block
    } req_type_t;

    // Which cache client a request or response belongs to
    typedef enum logic {
        ICACHE = 1'b0,
        DCACHE = 1'b1
    } cache_type_t;

endpackage

// ==== common/mem_req_if.sv ====
`timescale 1ns/1ps

// One arbitrated request, from the arbiter into main memory
interface mem_req_if;

    logic                   valid;       // Single-cycle strobe per request
    mem_pkg::cache_type_t   cache_type;  // Tag returned with the response
    mem_pkg::req_type_t     req_type;
    mem_pkg::block_addr_t   block_addr;
    mem_pkg::block_data_t   block_data;  // Only meaningful for writes

    // Arbiter side
    modport issuer (
        output valid,
        output cache_type,
        output req_type,
        output block_addr,
        output block_data
    );

    // Memory side, no back-pressure
    modport target (
        input valid,
        input cache_type,
        input req_type,
        input block_addr,
        input block_data
    );

endinterface

// ==== main_mem/main_mem.sv ====
`timescale 1ns/1ps

module main_mem #(
    parameter int unsigned N_DELAY_CYCLES = 5   // Must be 1 or more
) (
    input  logic                  clk,
    input  logic                  init,

    mem_req_if.target             req_in,

    // Broadcast to both client ports
    output logic                  resp_valid,
    output mem_pkg::cache_type_t  resp_cache_type,
    output mem_pkg::block_data_t  resp_block_data
);

    // One slot of the latency chain
    typedef struct packed {
        logic                  valid;
        mem_pkg::req_type_t    req_type;
        mem_pkg::cache_type_t  cache_type;
        mem_pkg::block_addr_t  addr;
        mem_pkg::block_data_t  data;
    } mem_slot_t;

    mem_pkg::block_data_t mem [mem_pkg::N_BLOCKS];
    mem_slot_t            chain [N_DELAY_CYCLES];
    mem_slot_t            head;     // Oldest request, serviced this cycle

    assign head = chain[N_DELAY_CYCLES-1];

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            for (int i = 0; i < N_DELAY_CYCLES; i++) begin
                chain[i] <= '0;
            end
            for (int b = 0; b < mem_pkg::N_BLOCKS; b++) begin
                mem[b] <= '0;
            end
            resp_valid      <= 1'b0;
            resp_cache_type <= mem_pkg::ICACHE;
            resp_block_data <= '0;
        end else begin
            // Advance every slot by one
            for (int i = N_DELAY_CYCLES - 1; i > 0; i--) begin
                chain[i] <= chain[i-1];
            end

            chain[0] <= '{
                valid:      req_in.valid,
                req_type:   req_in.req_type,
                cache_type: req_in.cache_type,
                addr:       req_in.block_addr,
                data:       req_in.block_data
            };

            resp_valid      <= head.valid;
            resp_cache_type <= head.cache_type;

            if (head.valid) begin
                // Old content goes back even on a write
                resp_block_data <= mem[head.addr];
                if (head.req_type == mem_pkg::WRITE) begin
                    mem[head.addr] <= head.data;
                end
            end else begin
                resp_block_data <= '0;
            end
        end
    end

endmodule

// ==== source/client_port.sv ====
`timescale 1ns/1ps

module client_port #(
    parameter mem_pkg::cache_type_t PORT_TYPE = mem_pkg::ICACHE
) (
    input  logic                  clk,
    input  logic                  init,

    // Four-phase client side
    input  logic                  req,
    input  logic                  we,
    input  mem_pkg::block_addr_t  addr,
    input  mem_pkg::block_data_t  wdata,
    output logic                  ack,
    output mem_pkg::block_data_t  rdata,

    // Towards the arbiter
    output logic                  pending,
    input  logic                  grant,
    output logic                  cap_we,
    output mem_pkg::block_addr_t  cap_addr,
    output mem_pkg::block_data_t  cap_wdata,

    // Broadcast response from memory
    input  logic                  resp_valid,
    input  mem_pkg::cache_type_t  resp_cache_type,
    input  mem_pkg::block_data_t  resp_block_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PENDING,   // Captured, waiting for a grant
        ST_WAITING,   // Issued, waiting for the tagged response
        ST_ACKED      // Holding ack until req drops
    } port_state_t;

    port_state_t state;
    logic        own_resp;

    // Only responses carrying our tag belong to this port
    assign own_resp = resp_valid && (resp_cache_type == PORT_TYPE);

    assign pending = (state == ST_PENDING);
    assign ack     = (state == ST_ACKED);

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:    if (req)      state <= ST_PENDING;
                ST_PENDING: if (grant)    state <= ST_WAITING;
                ST_WAITING: if (own_resp) state <= ST_ACKED;
                ST_ACKED:   if (!req)     state <= ST_IDLE;
                default:                  state <= ST_IDLE;
            endcase
        end
    end

    // Request fields are latched on the req rise and held until issued
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            cap_we    <= we;
            cap_addr  <= addr;
            cap_wdata <= wdata;
        end
    end

    // Response data stays stable for the whole ack phase
    always_ff @(posedge clk) begin
        if (state == ST_WAITING && own_resp) begin
            rdata <= resp_block_data;
        end
    end

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                  clk,
    input  logic                  init,

    input  logic                  icache_pending,
    input  logic                  dcache_pending,
    output logic                  icache_grant,
    output logic                  dcache_grant,

    input  logic                  icache_we,
    input  logic                  dcache_we,
    input  mem_pkg::block_addr_t  icache_addr,
    input  mem_pkg::block_addr_t  dcache_addr,
    input  mem_pkg::block_data_t  icache_wdata,
    input  mem_pkg::block_data_t  dcache_wdata,

    mem_req_if.issuer             req_out
);

    logic dcache_first;   // Set when dcache wins the next contention
    logic contended;
    logic pick_dcache;

    assign contended   = icache_pending && dcache_pending;
    assign pick_dcache = dcache_pending && (!icache_pending || dcache_first);

    // Grants are same-cycle and mutually exclusive
    assign dcache_grant = pick_dcache;
    assign icache_grant = icache_pending && !pick_dcache;

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            dcache_first  <= 1'b0;
            req_out.valid <= 1'b0;
        end else begin
            req_out.valid <= icache_pending || dcache_pending;
            // Loser of a contention gets priority next time
            if (contended) begin
                dcache_first <= !dcache_first;
            end
        end
    end

    // Request payload follows the winner
    always_ff @(posedge clk) begin
        if (pick_dcache) begin
            req_out.cache_type <= mem_pkg::DCACHE;
            req_out.req_type   <= dcache_we ? mem_pkg::WRITE : mem_pkg::READ;
            req_out.block_addr <= dcache_addr;
            req_out.block_data <= dcache_wdata;
        end else begin
            req_out.cache_type <= mem_pkg::ICACHE;
            req_out.req_type   <= icache_we ? mem_pkg::WRITE : mem_pkg::READ;
            req_out.block_addr <= icache_addr;
            req_out.block_data <= icache_wdata;
        end
    end

endmodule

// ==== source/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int unsigned N_DELAY_CYCLES = 5
) (
    input  logic                  clk,
    input  logic                  init,

    // Instruction cache client
    input  logic                  icache_req,
    output logic                  icache_ack,
    input  logic                  icache_we,
    input  mem_pkg::block_addr_t  icache_addr,
    input  mem_pkg::block_data_t  icache_wdata,
    output mem_pkg::block_data_t  icache_rdata,

    // Data cache client
    input  logic                  dcache_req,
    output logic                  dcache_ack,
    input  logic                  dcache_we,
    input  mem_pkg::block_addr_t  dcache_addr,
    input  mem_pkg::block_data_t  dcache_wdata,
    output mem_pkg::block_data_t  dcache_rdata
);

    logic                  icache_pending, dcache_pending;
    logic                  icache_grant, dcache_grant;
    logic                  icache_cap_we, dcache_cap_we;
    mem_pkg::block_addr_t  icache_cap_addr, dcache_cap_addr;
    mem_pkg::block_data_t  icache_cap_wdata, dcache_cap_wdata;

    // Shared response bus, steered by tag
    logic                  resp_valid;
    mem_pkg::cache_type_t  resp_cache_type;
    mem_pkg::block_data_t  resp_block_data;

    mem_req_if req_bus ();

    client_port #(.PORT_TYPE(mem_pkg::ICACHE)) u_icache_port (
        .clk             (clk),
        .init            (init),
        .req             (icache_req),
        .we              (icache_we),
        .addr            (icache_addr),
        .wdata           (icache_wdata),
        .ack             (icache_ack),
        .rdata           (icache_rdata),
        .pending         (icache_pending),
        .grant           (icache_grant),
        .cap_we          (icache_cap_we),
        .cap_addr        (icache_cap_addr),
        .cap_wdata       (icache_cap_wdata),
        .resp_valid      (resp_valid),
        .resp_cache_type (resp_cache_type),
        .resp_block_data (resp_block_data)
    );

    client_port #(.PORT_TYPE(mem_pkg::DCACHE)) u_dcache_port (
        .clk             (clk),
        .init            (init),
        .req             (dcache_req),
        .we              (dcache_we),
        .addr            (dcache_addr),
        .wdata           (dcache_wdata),
        .ack             (dcache_ack),
        .rdata           (dcache_rdata),
        .pending         (dcache_pending),
        .grant           (dcache_grant),
        .cap_we          (dcache_cap_we),
        .cap_addr        (dcache_cap_addr),
        .cap_wdata       (dcache_cap_wdata),
        .resp_valid      (resp_valid),
        .resp_cache_type (resp_cache_type),
        .resp_block_data (resp_block_data)
    );

    mem_arbiter u_arbiter (
        .clk            (clk),
        .init           (init),
        .icache_pending (icache_pending),
        .dcache_pending (dcache_pending),
        .icache_grant   (icache_grant),
        .dcache_grant   (dcache_grant),
        .icache_we      (icache_cap_we),
        .dcache_we      (dcache_cap_we),
        .icache_addr    (icache_cap_addr),
        .dcache_addr    (dcache_cap_addr),
        .icache_wdata   (icache_cap_wdata),
        .dcache_wdata   (dcache_cap_wdata),
        .req_out        (req_bus.issuer)
    );

    main_mem #(.N_DELAY_CYCLES(N_DELAY_CYCLES)) u_main_mem (
        .clk             (clk),
        .init            (init),
        .req_in          (req_bus.target),
        .resp_valid      (resp_valid),
        .resp_cache_type (resp_cache_type),
        .resp_block_data (resp_block_data)
    );

endmodule
